//--- logic/stq_pkg.sv
package stq_pkg;

  // ==================================================
  // Widths
  // ==================================================
  localparam int PADDR_W         = 32;
  localparam int XLEN_W          = 64;
  localparam int DCACHE_DATA_W   = 128;
  localparam int DCACHE_DATA_B_W = DCACHE_DATA_W / 8;  // 16 bytes per cache word
  localparam int SEQ_W           = 6;

  // Credit return width, up to one free plus one ignored dispatch
  localparam int CREDIT_W = 2;

  // Byte offset within a cache word
  localparam int DCACHE_OFS_W = $clog2(DCACHE_DATA_B_W);

  // ==================================================
  // Enums
  // ==================================================
  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2,
    SIZE_D = 2'd3
  } size_t;

  typedef enum logic [2:0] {
    STQ_INIT      = 3'd0,  // Free
    STQ_WAIT_EXEC = 3'd1,
    STQ_READY     = 3'd2,
    STQ_COMMIT    = 3'd3,
    STQ_L1D_WRITE = 3'd4,
    STQ_DEAD      = 3'd5
  } stq_state_t;

  // Doubleword byte mask, 2^size ones starting at the byte offset
  function automatic logic [7:0] gen_dw(size_t size, logic [2:0] ofs);
    logic [7:0] base;
    case (size)
      SIZE_B:  base = 8'h01;
      SIZE_H:  base = 8'h03;
      SIZE_W:  base = 8'h0f;
      default: base = 8'hff;
    endcase
    return base << ofs;
  endfunction

  // Same idea over a whole cache word
  function automatic logic [DCACHE_DATA_B_W-1:0] gen_line_be(size_t size,
                                                             logic [DCACHE_OFS_W-1:0] ofs);
    logic [DCACHE_DATA_B_W-1:0] base;
    case (size)
      SIZE_B:  base = DCACHE_DATA_B_W'(16'h0001);
      SIZE_H:  base = DCACHE_DATA_B_W'(16'h0003);
      SIZE_W:  base = DCACHE_DATA_B_W'(16'h000f);
      default: base = DCACHE_DATA_B_W'(16'h00ff);
    endcase
    return base << ofs;
  endfunction

endpackage

//--- logic/stq_entry.sv
`timescale 1ns/10ps

module stq_entry (
  input  logic                             i_clk,
  input  logic                             i_reset_n,

  // Dispatch
  input  logic                             i_disp_load,
  input  logic [stq_pkg::SEQ_W-1:0]        i_disp_seq,
  input  stq_pkg::size_t                   i_disp_size,

  // Execute
  input  logic                             i_ex_load,
  input  logic [stq_pkg::PADDR_W-1:0]      i_ex_paddr,
  input  logic [stq_pkg::XLEN_W-1:0]       i_ex_data,

  // Commit and flush
  input  logic                             i_commit_valid,
  input  logic [stq_pkg::SEQ_W-1:0]        i_commit_seq,
  input  logic                             i_flush,

  // Drain
  input  logic                             i_drain_pick,
  input  logic                             i_drain_done,
  input  logic                             i_drain_retry,
  input  logic                             i_free,

  output stq_pkg::stq_state_t              o_state,
  output logic [stq_pkg::SEQ_W-1:0]        o_seq,
  output stq_pkg::size_t                   o_size,
  output logic                             o_paddr_valid,
  output logic [stq_pkg::PADDR_W-1:0]      o_paddr,
  output logic [stq_pkg::XLEN_W-1:0]       o_data
);

  import stq_pkg::*;

  stq_state_t         r_state;
  logic [SEQ_W-1:0]   r_seq;
  size_t              r_size;
  logic               r_paddr_valid;
  logic [PADDR_W-1:0] r_paddr;
  logic [XLEN_W-1:0]  r_data;
  logic               w_commit_hit;

  assign w_commit_hit = i_commit_valid && (i_commit_seq == r_seq);

  // ==================================================
  // Lifecycle FSM
  // ==================================================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state       <= STQ_INIT;
      r_paddr_valid <= 1'b0;
    end else begin
      case (r_state)
        STQ_INIT: begin
          if (i_disp_load) r_state <= STQ_WAIT_EXEC;
        end
        STQ_WAIT_EXEC: begin
          if (i_flush) r_state <= STQ_DEAD;  // Flush wins over commit
          else if (w_commit_hit) r_state <= STQ_COMMIT;
          else if (i_ex_load) r_state <= STQ_READY;
        end
        STQ_READY: begin
          if (i_flush) r_state <= STQ_DEAD;
          else if (w_commit_hit) r_state <= STQ_COMMIT;
        end
        STQ_COMMIT: begin
          if (i_drain_pick) r_state <= STQ_L1D_WRITE;
        end
        STQ_L1D_WRITE: begin
          if (i_drain_done) r_state <= STQ_INIT;
          else if (i_drain_retry) r_state <= STQ_COMMIT;  // Cache busy, go again
        end
        STQ_DEAD: begin
          if (i_free) r_state <= STQ_INIT;
        end
        default: r_state <= STQ_INIT;
      endcase

      if (i_disp_load) r_paddr_valid <= 1'b0;
      else if (i_ex_load) r_paddr_valid <= 1'b1;
    end
  end

  // Store payload
  always_ff @(posedge i_clk) begin
    if (i_disp_load) begin
      r_seq  <= i_disp_seq;
      r_size <= i_disp_size;
    end
    if (i_ex_load) begin
      r_paddr <= i_ex_paddr;
      r_data  <= i_ex_data;
    end
  end

  assign o_state       = r_state;
  assign o_seq         = r_seq;
  assign o_size        = r_size;
  assign o_paddr_valid = r_paddr_valid;
  assign o_paddr       = r_paddr;
  assign o_data        = r_data;

endmodule

//--- logic/stq_ring_ctrl.sv
`timescale 1ns/10ps

module stq_ring_ctrl #(
  parameter int STQ_SIZE = 8
) (
  input  logic                            i_clk,
  input  logic                            i_reset_n,
  input  logic                            i_alloc,
  input  logic                            i_free,
  input  logic                            i_ignored_disp,
  output logic [$clog2(STQ_SIZE)-1:0]     o_tail,
  output logic [$clog2(STQ_SIZE)-1:0]     o_head,
  output logic                            o_credit_valid,
  output logic [stq_pkg::CREDIT_W-1:0]    o_credit_val
);

  import stq_pkg::*;

  localparam int IDX_W = $clog2(STQ_SIZE);

  logic [IDX_W-1:0]    r_tail;
  logic [IDX_W-1:0]    r_head;
  logic                r_credit_valid;
  logic [CREDIT_W-1:0] r_credit_val;

  // ==================================================
  // Pointers
  // ==================================================
  // Power-of-two size, so the wrap is free
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_tail <= '0;
      r_head <= '0;
    end else begin
      if (i_alloc) r_tail <= r_tail + IDX_W'(1);
      if (i_free)  r_head <= r_head + IDX_W'(1);
    end
  end

  // Credits back to dispatch, one cycle after the free
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_credit_valid <= 1'b0;
      r_credit_val   <= '0;
    end else begin
      r_credit_valid <= i_free | i_ignored_disp;
      r_credit_val   <= CREDIT_W'(i_free) + CREDIT_W'(i_ignored_disp);
    end
  end

  assign o_tail         = r_tail;
  assign o_head         = r_head;
  assign o_credit_valid = r_credit_valid;
  assign o_credit_val   = r_credit_val;

endmodule

//--- logic/stq_fwd_check.sv
`timescale 1ns/10ps

module stq_fwd_check #(
  parameter int STQ_SIZE = 8
) (
  input  logic                          i_fwd_valid,
  input  logic [stq_pkg::SEQ_W-1:0]     i_fwd_seq,
  input  logic [stq_pkg::PADDR_W-1:0]   i_fwd_paddr,
  input  stq_pkg::size_t                i_fwd_size,

  // Entry snapshot
  input  stq_pkg::stq_state_t           i_state       [STQ_SIZE],
  input  logic [stq_pkg::SEQ_W-1:0]     i_seq         [STQ_SIZE],
  input  stq_pkg::size_t                i_size        [STQ_SIZE],
  input  logic                          i_paddr_valid [STQ_SIZE],
  input  logic [stq_pkg::PADDR_W-1:0]   i_paddr       [STQ_SIZE],
  input  logic [stq_pkg::XLEN_W-1:0]    i_data        [STQ_SIZE],

  output logic                          o_fwd_valid,
  output logic [stq_pkg::XLEN_W-1:0]    o_fwd_data,
  output logic [7:0]                    o_fwd_be,
  output logic                          o_fwd_hazard
);

  import stq_pkg::*;

  localparam int IDX_W = $clog2(STQ_SIZE);

  logic [7:0]          w_load_dw;
  logic [SEQ_W-1:0]    w_dist    [STQ_SIZE];
  logic [7:0]          w_overlap [STQ_SIZE];
  logic [STQ_SIZE-1:0] w_match;
  logic [STQ_SIZE-1:0] w_hazard;
  logic                w_found;
  logic [SEQ_W-1:0]    w_best_dist;
  logic [IDX_W-1:0]    w_best_idx;

  assign w_load_dw = gen_dw(i_fwd_size, i_fwd_paddr[2:0]);

  // ==================================================
  // Per-entry age and address match
  // ==================================================
  for (genvar g = 0; g < STQ_SIZE; g++) begin : g_entry
    logic w_older;
    logic w_live;
    logic w_same_dw_addr;

    assign w_dist[g]      = i_fwd_seq - i_seq[g];  // Wraps modulo 2^SEQ_W
    assign w_older        = (w_dist[g] != '0) && !w_dist[g][SEQ_W-1];
    assign w_live         = (i_state[g] != STQ_INIT) && (i_state[g] != STQ_DEAD);
    assign w_same_dw_addr = i_paddr[g][PADDR_W-1:3] == i_fwd_paddr[PADDR_W-1:3];
    assign w_overlap[g]   = gen_dw(i_size[g], i_paddr[g][2:0]) & w_load_dw;

    assign w_match[g]  = i_fwd_valid && w_live && w_older && i_paddr_valid[g] &&
                         w_same_dw_addr && (|w_overlap[g]);
    assign w_hazard[g] = i_fwd_valid && w_live && w_older && !i_paddr_valid[g];
  end

  // Youngest older match is the one closest to the load
  always_comb begin
    w_found     = 1'b0;
    w_best_dist = '0;
    w_best_idx  = '0;
    for (int i = 0; i < STQ_SIZE; i++) begin
      if (w_match[i] && (!w_found || (w_dist[i] < w_best_dist))) begin
        w_found     = 1'b1;
        w_best_dist = w_dist[i];
        w_best_idx  = IDX_W'(i);
      end
    end
  end

  assign o_fwd_valid  = w_found;
  assign o_fwd_be     = w_found ? w_overlap[w_best_idx] : 8'h00;
  // Store data sits in the low bytes; move it to its doubleword lanes
  assign o_fwd_data   = i_data[w_best_idx] << {i_paddr[w_best_idx][2:0], 3'b000};
  assign o_fwd_hazard = |w_hazard;

endmodule

//--- logic/stq_l1d_drain.sv
`timescale 1ns/10ps

module stq_l1d_drain #(
  parameter int STQ_SIZE = 8
) (
  input  logic                                 i_clk,
  input  logic                                 i_reset_n,
  input  logic [$clog2(STQ_SIZE)-1:0]          i_head,

  input  stq_pkg::stq_state_t                  i_state [STQ_SIZE],
  input  stq_pkg::size_t                       i_size  [STQ_SIZE],
  input  logic [stq_pkg::PADDR_W-1:0]          i_paddr [STQ_SIZE],
  input  logic [stq_pkg::XLEN_W-1:0]           i_data  [STQ_SIZE],

  input  logic                                 i_l1d_wr_conflict,

  output logic                                 o_pick,
  output logic                                 o_done,
  output logic                                 o_retry,
  output logic                                 o_free_dead,

  output logic                                 o_l1d_wr_valid,
  output logic [stq_pkg::PADDR_W-1:0]          o_l1d_wr_paddr,
  output logic [stq_pkg::DCACHE_DATA_W-1:0]    o_l1d_wr_data,
  output logic [stq_pkg::DCACHE_DATA_B_W-1:0]  o_l1d_wr_be
);

  import stq_pkg::*;

  logic [PADDR_W-1:0]         w_head_paddr;
  logic [XLEN_W-1:0]          w_head_data;
  logic [DCACHE_DATA_W-1:0]   w_line_data;
  logic                       r_wr_valid;
  logic [PADDR_W-1:0]         r_wr_paddr;
  logic [DCACHE_DATA_W-1:0]   r_wr_data;
  logic [DCACHE_DATA_B_W-1:0] r_wr_be;

  assign w_head_paddr = i_paddr[i_head];
  assign w_head_data  = i_data[i_head];

  // Only the head is ever looked at, so writes leave in order
  assign o_pick      = i_state[i_head] == STQ_COMMIT;
  assign o_free_dead = i_state[i_head] == STQ_DEAD;
  assign o_done      = r_wr_valid & ~i_l1d_wr_conflict;
  assign o_retry     = r_wr_valid &  i_l1d_wr_conflict;

  // ==================================================
  // Cache word formatting
  // ==================================================
  always_comb begin
    case (i_size[i_head])
      SIZE_B:  w_line_data = {(DCACHE_DATA_W / 8){w_head_data[7:0]}};
      SIZE_H:  w_line_data = {(DCACHE_DATA_W / 16){w_head_data[15:0]}};
      SIZE_W:  w_line_data = {(DCACHE_DATA_W / 32){w_head_data[31:0]}};
      default: w_line_data = {(DCACHE_DATA_W / 64){w_head_data[63:0]}};
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wr_valid <= 1'b0;
    end else begin
      r_wr_valid <= o_pick;  // Entry leaves COMMIT on pick, so one in flight
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_pick) begin
      r_wr_paddr <= w_head_paddr;
      r_wr_data  <= w_line_data;
      r_wr_be    <= gen_line_be(i_size[i_head], w_head_paddr[DCACHE_OFS_W-1:0]);
    end
  end

  assign o_l1d_wr_valid = r_wr_valid;
  assign o_l1d_wr_paddr = r_wr_paddr;
  assign o_l1d_wr_data  = r_wr_data;
  assign o_l1d_wr_be    = r_wr_be;

endmodule

//--- logic/stq_top.sv
`timescale 1ns/10ps

module stq_top #(
  parameter int STQ_SIZE = 8
) (
  input  logic                                 i_clk,
  input  logic                                 i_reset_n,

  // Dispatch and credits
  input  logic                                 i_disp_valid,
  input  logic [stq_pkg::SEQ_W-1:0]            i_disp_seq,
  input  stq_pkg::size_t                       i_disp_size,
  output logic [$clog2(STQ_SIZE)-1:0]          o_disp_index,
  output logic                                 o_credit_valid,
  output logic [stq_pkg::CREDIT_W-1:0]         o_credit_val,

  // Execute
  input  logic                                 i_ex_valid,
  input  logic [$clog2(STQ_SIZE)-1:0]          i_ex_index,
  input  logic [stq_pkg::PADDR_W-1:0]          i_ex_paddr,
  input  logic [stq_pkg::XLEN_W-1:0]           i_ex_data,

  // Commit and flush
  input  logic                                 i_commit_valid,
  input  logic [stq_pkg::SEQ_W-1:0]            i_commit_seq,
  input  logic                                 i_flush,

  // Load forwarding
  input  logic                                 i_fwd_valid,
  input  logic [stq_pkg::SEQ_W-1:0]            i_fwd_seq,
  input  logic [stq_pkg::PADDR_W-1:0]          i_fwd_paddr,
  input  stq_pkg::size_t                       i_fwd_size,
  output logic                                 o_fwd_valid,
  output logic [stq_pkg::XLEN_W-1:0]           o_fwd_data,
  output logic [7:0]                           o_fwd_be,
  output logic                                 o_fwd_hazard,

  // Cache write
  output logic                                 o_l1d_wr_valid,
  output logic [stq_pkg::PADDR_W-1:0]          o_l1d_wr_paddr,
  output logic [stq_pkg::DCACHE_DATA_W-1:0]    o_l1d_wr_data,
  output logic [stq_pkg::DCACHE_DATA_B_W-1:0]  o_l1d_wr_be,
  input  logic                                 i_l1d_wr_conflict
);

  import stq_pkg::*;

  localparam int IDX_W = $clog2(STQ_SIZE);

  stq_state_t         w_state       [STQ_SIZE];
  logic [SEQ_W-1:0]   w_seq         [STQ_SIZE];
  size_t              w_size        [STQ_SIZE];
  logic               w_paddr_valid [STQ_SIZE];
  logic [PADDR_W-1:0] w_paddr       [STQ_SIZE];
  logic [XLEN_W-1:0]  w_data        [STQ_SIZE];

  logic [IDX_W-1:0]   w_tail;
  logic [IDX_W-1:0]   w_head;
  logic               w_alloc;
  logic               w_ignored_disp;
  logic               w_pick;
  logic               w_done;
  logic               w_retry;
  logic               w_free_dead;

  assign w_alloc        = i_disp_valid & ~i_flush;
  assign w_ignored_disp = i_disp_valid &  i_flush;  // Dropped, credit goes straight back
  assign o_disp_index   = w_tail;

  // ==================================================
  // Entry array
  // ==================================================
  for (genvar g = 0; g < STQ_SIZE; g++) begin : g_stq
    logic w_head_hit;

    assign w_head_hit = w_head == IDX_W'(g);

    stq_entry u_entry (
      .i_clk          (i_clk),
      .i_reset_n      (i_reset_n),
      .i_disp_load    (w_alloc && (w_tail == IDX_W'(g))),
      .i_disp_seq     (i_disp_seq),
      .i_disp_size    (i_disp_size),
      .i_ex_load      (i_ex_valid && (i_ex_index == IDX_W'(g))),
      .i_ex_paddr     (i_ex_paddr),
      .i_ex_data      (i_ex_data),
      .i_commit_valid (i_commit_valid),
      .i_commit_seq   (i_commit_seq),
      .i_flush        (i_flush),
      .i_drain_pick   (w_pick & w_head_hit),
      .i_drain_done   (w_done & w_head_hit),
      .i_drain_retry  (w_retry & w_head_hit),
      .i_free         (w_free_dead & w_head_hit),
      .o_state        (w_state[g]),
      .o_seq          (w_seq[g]),
      .o_size         (w_size[g]),
      .o_paddr_valid  (w_paddr_valid[g]),
      .o_paddr        (w_paddr[g]),
      .o_data         (w_data[g])
    );
  end

  stq_ring_ctrl #(.STQ_SIZE(STQ_SIZE)) u_ring_ctrl (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_alloc        (w_alloc),
    .i_free         (w_done | w_free_dead),  // At most one per cycle
    .i_ignored_disp (w_ignored_disp),
    .o_tail         (w_tail),
    .o_head         (w_head),
    .o_credit_valid (o_credit_valid),
    .o_credit_val   (o_credit_val)
  );

  stq_fwd_check #(.STQ_SIZE(STQ_SIZE)) u_fwd_check (
    .i_fwd_valid   (i_fwd_valid),
    .i_fwd_seq     (i_fwd_seq),
    .i_fwd_paddr   (i_fwd_paddr),
    .i_fwd_size    (i_fwd_size),
    .i_state       (w_state),
    .i_seq         (w_seq),
    .i_size        (w_size),
    .i_paddr_valid (w_paddr_valid),
    .i_paddr       (w_paddr),
    .i_data        (w_data),
    .o_fwd_valid   (o_fwd_valid),
    .o_fwd_data    (o_fwd_data),
    .o_fwd_be      (o_fwd_be),
    .o_fwd_hazard  (o_fwd_hazard)
  );

  stq_l1d_drain #(.STQ_SIZE(STQ_SIZE)) u_l1d_drain (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_head            (w_head),
    .i_state           (w_state),
    .i_size            (w_size),
    .i_paddr           (w_paddr),
    .i_data            (w_data),
    .i_l1d_wr_conflict (i_l1d_wr_conflict),
    .o_pick            (w_pick),
    .o_done            (w_done),
    .o_retry           (w_retry),
    .o_free_dead       (w_free_dead),
    .o_l1d_wr_valid    (o_l1d_wr_valid),
    .o_l1d_wr_paddr    (o_l1d_wr_paddr),
    .o_l1d_wr_data     (o_l1d_wr_data),
    .o_l1d_wr_be       (o_l1d_wr_be)
  );

endmodule

//--- testbench/stq_tb_tasks.svh
// ==================================================
// Reference model helpers
// ==================================================
function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return lcg_state;
endfunction

// One bit per byte of a 2^size access
function automatic int access_ones(logic [1:0] size);
  return (1 << (1 << size)) - 1;
endfunction

function automatic logic [7:0] byte_mask(logic [1:0] size, logic [2:0] ofs);
  return 8'(access_ones(size) << ofs);
endfunction

function automatic logic [15:0] line_be(logic [1:0] size, logic [3:0] ofs);
  return 16'(access_ones(size) << ofs);
endfunction

// Low 2^size bytes repeated over the whole cache word
function automatic logic [127:0] line_data(logic [1:0] size, logic [63:0] data);
  logic [127:0] word;
  int           nbytes;
  nbytes = 1 << size;
  for (int i = 0; i < 16; i++) begin
    word[i*8 +: 8] = data[(i % nbytes)*8 +: 8];
  end
  return word;
endfunction

function automatic logic [31:0] aligned_paddr(logic [1:0] size);
  logic [31:0] p;
  p = lcg_next();
  return p & ~((32'd1 << size) - 32'd1);  // Natural alignment
endfunction

task automatic report_value(input string name, input logic [127:0] got,
                            input logic [127:0] exp);
  errors++;
  $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
endtask

task automatic clear_log();
  wr_paddr_q.delete();
  wr_data_q.delete();
  wr_be_q.delete();
endtask

// ==================================================
// Drivers and waits
// ==================================================
task automatic dispatch_store(input logic [1:0] size, output logic [2:0] idx,
                              output logic [5:0] seq);
  @(negedge i_clk);
  i_disp_valid = 1'b1;
  i_disp_seq   = next_seq;
  i_disp_size  = size_t'(size);
  idx          = o_disp_index;
  seq          = next_seq;
  if (o_disp_index !== exp_tail) report_value("o_disp_index", o_disp_index, exp_tail);
  next_seq++;
  exp_tail++;  // Wraps modulo 8 with the ring
  @(negedge i_clk);
  i_disp_valid = 1'b0;
endtask

task automatic execute_store(input logic [2:0] idx, input logic [31:0] paddr,
                             input logic [63:0] data);
  @(negedge i_clk);
  i_ex_valid = 1'b1;
  i_ex_index = idx;
  i_ex_paddr = paddr;
  i_ex_data  = data;
  @(negedge i_clk);
  i_ex_valid = 1'b0;
endtask

task automatic commit_store(input logic [5:0] seq);
  @(negedge i_clk);
  i_commit_valid = 1'b1;
  i_commit_seq   = seq;
  @(negedge i_clk);
  i_commit_valid = 1'b0;
endtask

task automatic wait_writes(input int n);
  int cycles;
  cycles = 0;
  while (wr_paddr_q.size() < n && cycles < TIMEOUT) begin
    @(posedge i_clk);
    cycles++;
  end
  if (wr_paddr_q.size() < n) begin
    timeouts++;
    $display("Timeout while waiting for %0d cache writes, saw %0d", n, wr_paddr_q.size());
  end
endtask

// Waits for the owed credits and then a few quiet cycles for any extras
task automatic wait_credit_total();
  int cycles;
  cycles = 0;
  while (credit_sum < exp_credits && cycles < TIMEOUT) begin
    @(posedge i_clk);
    cycles++;
  end
  if (credit_sum < exp_credits) begin
    timeouts++;
    $display("Timeout while waiting for credits, got %0d of %0d", credit_sum, exp_credits);
  end
  repeat (3) @(posedge i_clk);
  if (credit_sum != exp_credits) report_value("o_credit_val total", credit_sum, exp_credits);
endtask

task automatic check_write(input int k, input logic [31:0] paddr, input logic [1:0] size,
                           input logic [63:0] data);
  if (k < wr_paddr_q.size()) begin
    if (wr_paddr_q[k] !== paddr) report_value("o_l1d_wr_paddr", wr_paddr_q[k], paddr);
    if (wr_data_q[k] !== line_data(size, data)) begin
      report_value("o_l1d_wr_data", wr_data_q[k], line_data(size, data));
    end
    if (wr_be_q[k] !== line_be(size, paddr[3:0])) begin
      report_value("o_l1d_wr_be", wr_be_q[k], line_be(size, paddr[3:0]));
    end
  end
endtask

// Combinational answer is sampled a little after the drive
task automatic check_load(input logic [5:0] seq, input logic [31:0] paddr,
                          input logic [1:0] size, input logic exp_valid,
                          input logic [7:0] exp_be, input logic [63:0] exp_data,
                          input logic exp_hazard);
  @(negedge i_clk);
  i_fwd_valid = 1'b1;
  i_fwd_seq   = seq;
  i_fwd_paddr = paddr;
  i_fwd_size  = size_t'(size);
  #1;
  if (o_fwd_valid !== exp_valid) report_value("o_fwd_valid", o_fwd_valid, exp_valid);
  if (o_fwd_hazard !== exp_hazard) report_value("o_fwd_hazard", o_fwd_hazard, exp_hazard);
  if (exp_valid && o_fwd_be !== exp_be) report_value("o_fwd_be", o_fwd_be, exp_be);
  if (exp_valid && o_fwd_data !== exp_data) report_value("o_fwd_data", o_fwd_data, exp_data);
  @(negedge i_clk);
  i_fwd_valid = 1'b0;
endtask

// ==================================================
// Directed tests
// ==================================================
task automatic check_reset_state();
  if (o_l1d_wr_valid !== 1'b0) report_value("o_l1d_wr_valid", o_l1d_wr_valid, 0);
  if (o_credit_valid !== 1'b0) report_value("o_credit_valid", o_credit_valid, 0);
  if (o_disp_index !== 3'd0) report_value("o_disp_index", o_disp_index, 0);
endtask

task automatic test_drain_format();
  logic [2:0]  idx;
  logic [5:0]  seq;
  logic [31:0] paddr;
  logic [63:0] data;
  clear_log();
  for (int s = 0; s < 4; s++) begin
    paddr = aligned_paddr(2'(s));
    data  = {lcg_next(), lcg_next()};
    dispatch_store(2'(s), idx, seq);
    execute_store(idx, paddr, data);
    commit_store(seq);
    wait_writes(s + 1);
    check_write(s, paddr, 2'(s), data);
    exp_credits++;
  end
endtask

// Six stores make the tail wrap past 7
task automatic test_order_credits();
  logic [2:0]  idx   [6];
  logic [5:0]  seq   [6];
  logic [31:0] paddr [6];
  logic [63:0] data  [6];
  logic [2:0]  t_idx;
  logic [5:0]  t_seq;
  clear_log();
  for (int i = 0; i < 6; i++) begin
    paddr[i] = aligned_paddr(2'd3);
    data[i]  = {lcg_next(), lcg_next()};
    dispatch_store(2'd3, t_idx, t_seq);
    idx[i] = t_idx;
    seq[i] = t_seq;
  end
  for (int i = 0; i < 6; i++) execute_store(idx[i], paddr[i], data[i]);
  for (int i = 0; i < 6; i++) commit_store(seq[i]);
  wait_writes(6);
  for (int i = 0; i < 6; i++) check_write(i, paddr[i], 2'd3, data[i]);
  exp_credits += 6;
  wait_credit_total();
endtask

task automatic test_forwarding();
  logic [1:0]  size [4];
  logic [2:0]  ofs  [4];
  logic [2:0]  idx  [4];
  logic [5:0]  seq  [4];
  logic [63:0] data [4];
  logic [31:0] base;
  logic [5:0]  load_seq;
  size = '{2'd3, 2'd2, 2'd1, 2'd0};
  ofs  = '{3'd0, 3'd4, 3'd4, 3'd4};
  base = aligned_paddr(2'd3);
  clear_log();
  for (int i = 0; i < 4; i++) begin
    if (i == 3) begin
      load_seq = next_seq;  // Last store is younger than the load
      next_seq++;
    end
    data[i] = {lcg_next(), lcg_next()};
    dispatch_store(size[i], idx[i], seq[i]);
  end
  for (int i = 0; i < 4; i++) execute_store(idx[i], base + 32'(ofs[i]), data[i]);
  // Youngest older overlap of a word load at +4 is the halfword
  check_load(load_seq, base + 32'd4, 2'd2, 1'b1, byte_mask(size[2], 3'd4) & byte_mask(2'd2, 3'd4),
             data[2] << 32, 1'b0);
  // Halfword at +0 only overlaps the doubleword
  check_load(load_seq, base, 2'd1, 1'b1, byte_mask(size[0], 3'd0) & byte_mask(2'd1, 3'd0),
             data[0], 1'b0);
  // Load older than all four stores sees none of them
  check_load(seq[0] - 6'd1, base + 32'd4, 2'd0, 1'b0, 8'h00, 64'h0, 1'b0);
  for (int i = 0; i < 4; i++) commit_store(seq[i]);
  wait_writes(4);
  for (int i = 0; i < 4; i++) check_write(i, base + 32'(ofs[i]), size[i], data[i]);
  exp_credits += 4;
endtask

task automatic test_hazard();
  logic [2:0]  idx;
  logic [5:0]  seq;
  logic [31:0] paddr;
  logic [63:0] data;
  paddr = aligned_paddr(2'd2);
  data  = {lcg_next(), lcg_next()};
  clear_log();
  dispatch_store(2'd2, idx, seq);
  check_load(next_seq, paddr, 2'd2, 1'b0, 8'h00, 64'h0, 1'b1);
  execute_store(idx, paddr, data);
  check_load(next_seq, paddr, 2'd2, 1'b1, byte_mask(2'd2, paddr[2:0]),
             data << (8 * paddr[2:0]), 1'b0);
  commit_store(seq);
  wait_writes(1);
  check_write(0, paddr, 2'd2, data);
  exp_credits++;
endtask

task automatic test_flush();
  logic [2:0]  idx   [3];
  logic [5:0]  seq   [3];
  logic [31:0] paddr [3];
  logic [63:0] data  [3];
  for (int i = 0; i < 3; i++) begin
    paddr[i] = aligned_paddr(2'd3);
    data[i]  = {lcg_next(), lcg_next()};
  end
  clear_log();
  dispatch_store(2'd3, idx[0], seq[0]);
  execute_store(idx[0], paddr[0], data[0]);
  dispatch_store(2'd3, idx[1], seq[1]);
  dispatch_store(2'd3, idx[2], seq[2]);
  execute_store(idx[1], paddr[1], data[1]);  // One READY and one still waiting
  commit_store(seq[0]);
  @(negedge i_clk);
  i_flush      = 1'b1;
  i_disp_valid = 1'b1;  // Dropped by the flush
  i_disp_seq   = next_seq;
  i_disp_size  = SIZE_B;
  if (o_disp_index !== exp_tail) report_value("o_disp_index", o_disp_index, exp_tail);
  @(negedge i_clk);
  i_flush      = 1'b0;
  i_disp_valid = 1'b0;
  exp_credits += 4;
  wait_writes(1);
  wait_credit_total();
  if (wr_paddr_q.size() != 1) begin
    errors++;
    $display("Flushed stores reached the cache, %0d writes seen", wr_paddr_q.size());
  end
  check_write(0, paddr[0], 2'd3, data[0]);
endtask

task automatic test_conflict();
  logic [2:0]  idx;
  logic [5:0]  seq;
  logic [1:0]  size;
  logic [31:0] paddr;
  logic [63:0] data;
  int          n;
  size  = 2'(lcg_next() >> 30);
  paddr = aligned_paddr(size);
  data  = {lcg_next(), lcg_next()};
  clear_log();
  dispatch_store(size, idx, seq);
  execute_store(idx, paddr, data);
  @(negedge i_clk);
  i_l1d_wr_conflict = 1'b1;
  commit_store(seq);
  wait_writes(3);
  @(negedge i_clk);
  if (credit_sum != exp_credits) begin
    errors++;
    $display("Credit came back while the cache write was still conflicted");
  end
  i_l1d_wr_conflict = 1'b0;
  exp_credits++;
  wait_credit_total();
  n = wr_paddr_q.size();
  repeat (4) @(posedge i_clk);
  if (wr_paddr_q.size() != n) begin
    errors++;
    $display("Cache write reissued after it had completed");
  end
  for (int k = 0; k < wr_paddr_q.size(); k++) check_write(k, paddr, size, data);
endtask

//--- testbench/stq_tb.sv
`timescale 1ns/10ps

module stq_tb;

  import stq_pkg::*;

  localparam int STQ_SIZE = 8;
  localparam int TIMEOUT  = 100;  // Cycles allowed per wait

  logic         i_clk;
  logic         i_reset_n;
  logic         i_disp_valid;
  logic [5:0]   i_disp_seq;
  size_t        i_disp_size;
  logic [2:0]   o_disp_index;
  logic         o_credit_valid;
  logic [1:0]   o_credit_val;
  logic         i_ex_valid;
  logic [2:0]   i_ex_index;
  logic [31:0]  i_ex_paddr;
  logic [63:0]  i_ex_data;
  logic         i_commit_valid;
  logic [5:0]   i_commit_seq;
  logic         i_flush;
  logic         i_fwd_valid;
  logic [5:0]   i_fwd_seq;
  logic [31:0]  i_fwd_paddr;
  size_t        i_fwd_size;
  logic         o_fwd_valid;
  logic [63:0]  o_fwd_data;
  logic [7:0]   o_fwd_be;
  logic         o_fwd_hazard;
  logic         o_l1d_wr_valid;
  logic [31:0]  o_l1d_wr_paddr;
  logic [127:0] o_l1d_wr_data;
  logic [15:0]  o_l1d_wr_be;
  logic         i_l1d_wr_conflict;

  int           errors;
  int           timeouts;
  logic [31:0]  lcg_state;
  logic [5:0]   next_seq;
  logic [2:0]   exp_tail;
  int           exp_credits;  // Running total of credits owed to dispatch
  int           credit_sum;
  logic [31:0]  wr_paddr_q [$];
  logic [127:0] wr_data_q  [$];
  logic [15:0]  wr_be_q    [$];

  `include "stq_tb_tasks.svh"

  stq_top #(.STQ_SIZE(STQ_SIZE)) uut (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_disp_valid      (i_disp_valid),
    .i_disp_seq        (i_disp_seq),
    .i_disp_size       (i_disp_size),
    .o_disp_index      (o_disp_index),
    .o_credit_valid    (o_credit_valid),
    .o_credit_val      (o_credit_val),
    .i_ex_valid        (i_ex_valid),
    .i_ex_index        (i_ex_index),
    .i_ex_paddr        (i_ex_paddr),
    .i_ex_data         (i_ex_data),
    .i_commit_valid    (i_commit_valid),
    .i_commit_seq      (i_commit_seq),
    .i_flush           (i_flush),
    .i_fwd_valid       (i_fwd_valid),
    .i_fwd_seq         (i_fwd_seq),
    .i_fwd_paddr       (i_fwd_paddr),
    .i_fwd_size        (i_fwd_size),
    .o_fwd_valid       (o_fwd_valid),
    .o_fwd_data        (o_fwd_data),
    .o_fwd_be          (o_fwd_be),
    .o_fwd_hazard      (o_fwd_hazard),
    .o_l1d_wr_valid    (o_l1d_wr_valid),
    .o_l1d_wr_paddr    (o_l1d_wr_paddr),
    .o_l1d_wr_data     (o_l1d_wr_data),
    .o_l1d_wr_be       (o_l1d_wr_be),
    .i_l1d_wr_conflict (i_l1d_wr_conflict)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // Registered outputs, so mid-cycle sampling is stable
  always @(negedge i_clk) begin
    if (o_credit_valid) credit_sum += o_credit_val;
    if (o_l1d_wr_valid) begin
      wr_paddr_q.push_back(o_l1d_wr_paddr);
      wr_data_q.push_back(o_l1d_wr_data);
      wr_be_q.push_back(o_l1d_wr_be);
    end
  end

  // ==================================================
  // Test sequence
  // ==================================================
  initial begin
    errors            = 0;
    timeouts          = 0;
    lcg_state         = 32'h49e8;
    next_seq          = '0;
    exp_tail          = '0;
    exp_credits       = 0;
    credit_sum        = 0;
    i_reset_n         = 1'b0;
    i_disp_valid      = 1'b0;
    i_disp_seq        = '0;
    i_disp_size       = SIZE_B;
    i_ex_valid        = 1'b0;
    i_ex_index        = '0;
    i_ex_paddr        = '0;
    i_ex_data         = '0;
    i_commit_valid    = 1'b0;
    i_commit_seq      = '0;
    i_flush           = 1'b0;
    i_fwd_valid       = 1'b0;
    i_fwd_seq         = '0;
    i_fwd_paddr       = '0;
    i_fwd_size        = SIZE_B;
    i_l1d_wr_conflict = 1'b0;

    repeat (3) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;

    check_reset_state();
    test_drain_format();
    test_order_credits();
    test_forwarding();
    test_hazard();
    test_flush();
    test_conflict();

    $display("Value errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- stq_top.f
+incdir+testbench
logic/stq_pkg.sv
logic/stq_entry.sv
logic/stq_ring_ctrl.sv
logic/stq_fwd_check.sv
logic/stq_l1d_drain.sv
logic/stq_top.sv
testbench/stq_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the store queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -Wno-fatal --top-module stq_tb -f stq_top.f \
  -Mdir "$OBJ" -o stq_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/stq_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$LOG"; then
  echo "FAIL"
  exit 1
fi
echo "PASS"
exit 0
